//--- rtl/pad_ctrl_pkg.sv
// Shared definitions for the pad multiplexer
// Pad count and pad indices, function select encoding,
// pad configuration and per-pad array types

package pad_ctrl_pkg;

   ////////////////////
   // Pad frame

   localparam int unsigned N_PADS    = 11;
   localparam int unsigned PAD_CFG_W = 6;

   // Pad indices
   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_CSN1  = 5;
   localparam int unsigned PAD_SPIM_SCK   = 6;
   localparam int unsigned PAD_UART_RX    = 7;
   localparam int unsigned PAD_UART_TX    = 8;
   localparam int unsigned PAD_I2C0_SDA   = 9;
   localparam int unsigned PAD_I2C0_SCL   = 10;

   ////////////////////
   // Types

   // Pad address on the config port, wide enough for out-of-range values
   typedef logic [3:0] pad_idx_t;

   // Function select per pad
   typedef enum logic [1:0] {
      FUNC_PERIPH = 2'b00,
      FUNC_GPIO   = 2'b01,
      FUNC_ALT    = 2'b10,
      FUNC_NONE   = 2'b11
   } pad_sel_e;

   typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

   // One bit per pad
   typedef logic [N_PADS-1:0] pad_vec_t;

   typedef pad_sel_e [N_PADS-1:0] pad_sel_arr_t;
   typedef pad_cfg_t [N_PADS-1:0] pad_cfg_arr_t;

endpackage

//--- rtl/pad_periph_if.sv
// Peripheral side of the pad multiplexer
// Outbound SPI, UART, I2C and GPIO signals plus the routed inputs

`timescale 1ns/1ps

interface pad_periph_if;
   import pad_ctrl_pkg::*;

   // Towards the pads
   logic         spi_clk;
   logic [1:0]   spi_csn;
   logic [3:0]   spi_sdo;
   logic [3:0]   spi_oen;
   logic         uart_tx;
   logic [1:0]   i2c_sda_out;
   logic [1:0]   i2c_sda_oe;
   logic [1:0]   i2c_scl_out;
   logic [1:0]   i2c_scl_oe;
   pad_vec_t     gpio_out;
   pad_vec_t     gpio_dir;
   pad_cfg_arr_t gpio_cfg;

   // From the pads
   logic [3:0]   spi_sdi;
   logic         uart_rx;
   logic [1:0]   i2c_sda_in;
   logic [1:0]   i2c_scl_in;
   pad_vec_t     gpio_in;

   modport top (
      output spi_clk, spi_csn, spi_sdo, spi_oen, uart_tx,
      output i2c_sda_out, i2c_sda_oe, i2c_scl_out, i2c_scl_oe,
      output gpio_out, gpio_dir, gpio_cfg,
      input  spi_sdi, uart_rx, i2c_sda_in, i2c_scl_in, gpio_in
   );

   modport out_side (
      input spi_clk, spi_csn, spi_sdo, spi_oen, uart_tx,
      input i2c_sda_out, i2c_sda_oe, i2c_scl_out, i2c_scl_oe,
      input gpio_out, gpio_dir, gpio_cfg
   );

   modport in_side (
      output spi_sdi, uart_rx, i2c_sda_in, i2c_scl_in, gpio_in
   );

endinterface

//--- rtl/pad_cfg_regs.sv
// Pad select and configuration register bank
// Written one pad at a time over a four-phase req/ack port

`timescale 1ns/1ps

module pad_cfg_regs (
   input  logic                        clk_i,
   input  logic                        reset_i,

   // Write port
   input  logic                        cfg_req_i,
   input  pad_ctrl_pkg::pad_idx_t      cfg_pad_i,
   input  pad_ctrl_pkg::pad_sel_e      cfg_sel_i,
   input  pad_ctrl_pkg::pad_cfg_t      cfg_pad_cfg_i,
   output logic                        cfg_ack_o,

   // Register contents
   output pad_ctrl_pkg::pad_sel_arr_t  pad_sel_o,
   output pad_ctrl_pkg::pad_cfg_arr_t  pad_cfg_o
);
   import pad_ctrl_pkg::*;

   pad_sel_arr_t sel_q;
   pad_cfg_arr_t cfg_q;
   logic         ack_q;
   logic         new_req;
   logic         addr_ok;
   logic         wr_en;

   ////////////////////
   // Handshake

   // Rising req not yet acknowledged
   assign new_req = cfg_req_i & ~ack_q;

   // Out-of-range pads still get an ack
   assign addr_ok = (cfg_pad_i < pad_idx_t'(N_PADS));
   assign wr_en   = new_req & addr_ok;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         // Ack follows req up and down, one edge late
         ack_q <= cfg_req_i;
      end
   end

   ////////////////////
   // Registers

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int p = 0; p < N_PADS; p++) begin
            sel_q[p] <= FUNC_PERIPH;
            cfg_q[p] <= '0;
         end
      end else if (wr_en) begin
         sel_q[cfg_pad_i] <= cfg_sel_i;
         cfg_q[cfg_pad_i] <= cfg_pad_cfg_i;
      end
   end

   assign cfg_ack_o = ack_q;
   assign pad_sel_o = sel_q;
   assign pad_cfg_o = cfg_q;

endmodule

//--- rtl/pad_out_mux.sv
// Output side of the pad multiplexer
// Per-pad choice of output value, output enable and pad configuration

`timescale 1ns/1ps

module pad_out_mux (
   pad_periph_if.out_side              periph,
   input  pad_ctrl_pkg::pad_sel_arr_t  pad_sel_i,
   input  pad_ctrl_pkg::pad_cfg_arr_t  pad_cfg_i,
   output pad_ctrl_pkg::pad_vec_t      pad_out_o,
   output pad_ctrl_pkg::pad_vec_t      pad_oe_o,
   output pad_ctrl_pkg::pad_cfg_arr_t  pad_cfg_o
);
   import pad_ctrl_pkg::*;

   pad_vec_t periph_out;
   pad_vec_t periph_oe;
   pad_vec_t alt_out;
   pad_vec_t alt_oe;

   ////////////////////
   // Peripheral function

   always_comb begin
      periph_out = '0;
      periph_oe  = '0;

      // Quad SPI data lines, oen is active low
      for (int i = 0; i < 4; i++) begin
         periph_out[PAD_SPIM_SDIO0 + i] = periph.spi_sdo[i];
         periph_oe[PAD_SPIM_SDIO0 + i]  = ~periph.spi_oen[i];
      end

      periph_out[PAD_SPIM_CSN0] = periph.spi_csn[0];
      periph_oe[PAD_SPIM_CSN0]  = 1'b1;
      periph_out[PAD_SPIM_CSN1] = periph.spi_csn[1];
      periph_oe[PAD_SPIM_CSN1]  = 1'b1;
      periph_out[PAD_SPIM_SCK]  = periph.spi_clk;
      periph_oe[PAD_SPIM_SCK]   = 1'b1;

      // UART rx pad is input only
      periph_out[PAD_UART_TX] = periph.uart_tx;
      periph_oe[PAD_UART_TX]  = 1'b1;

      periph_out[PAD_I2C0_SDA] = periph.i2c_sda_out[0];
      periph_oe[PAD_I2C0_SDA]  = periph.i2c_sda_oe[0];
      periph_out[PAD_I2C0_SCL] = periph.i2c_scl_out[0];
      periph_oe[PAD_I2C0_SCL]  = periph.i2c_scl_oe[0];
   end

   ////////////////////
   // Alternate function

   // I2C1 on sdio2/sdio3 and on uart_rx/uart_tx
   always_comb begin
      alt_out = '0;
      alt_oe  = '0;
      alt_out[PAD_SPIM_SDIO2] = periph.i2c_sda_out[1];
      alt_oe[PAD_SPIM_SDIO2]  = periph.i2c_sda_oe[1];
      alt_out[PAD_SPIM_SDIO3] = periph.i2c_scl_out[1];
      alt_oe[PAD_SPIM_SDIO3]  = periph.i2c_scl_oe[1];
      alt_out[PAD_UART_RX]    = periph.i2c_sda_out[1];
      alt_oe[PAD_UART_RX]     = periph.i2c_sda_oe[1];
      alt_out[PAD_UART_TX]    = periph.i2c_scl_out[1];
      alt_oe[PAD_UART_TX]     = periph.i2c_scl_oe[1];
   end

   ////////////////////
   // Per-pad select

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         case (pad_sel_i[p])
            FUNC_PERIPH: begin
               pad_out_o[p] = periph_out[p];
               pad_oe_o[p]  = periph_oe[p];
            end
            FUNC_GPIO: begin
               pad_out_o[p] = periph.gpio_out[p];
               pad_oe_o[p]  = periph.gpio_dir[p];
            end
            FUNC_ALT: begin
               pad_out_o[p] = alt_out[p];
               pad_oe_o[p]  = alt_oe[p];
            end
            default: begin
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase

         // GPIO owns the pad config while selected
         pad_cfg_o[p] = (pad_sel_i[p] == FUNC_GPIO) ? periph.gpio_cfg[p] : pad_cfg_i[p];
      end
   end

endmodule

//--- rtl/pad_in_route.sv
// Input side of the pad multiplexer
// Routes pad values to SPI, UART, both I2C buses and GPIO

`timescale 1ns/1ps

module pad_in_route (
   pad_periph_if.in_side               periph,
   input  pad_ctrl_pkg::pad_sel_arr_t  pad_sel_i,
   input  pad_ctrl_pkg::pad_vec_t      pad_in_i
);
   import pad_ctrl_pkg::*;

   pad_vec_t is_periph;
   pad_vec_t is_gpio;
   pad_vec_t is_alt;
   logic     i2c0_sda;
   logic     i2c0_scl;
   logic     i2c1_sda;
   logic     i2c1_scl;

   // Decoded selects
   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         is_periph[p] = (pad_sel_i[p] == FUNC_PERIPH);
         is_gpio[p]   = (pad_sel_i[p] == FUNC_GPIO);
         is_alt[p]    = (pad_sel_i[p] == FUNC_ALT);
      end
   end

   ////////////////////
   // Peripheral inputs

   // Idle levels: SPI low, UART and I2C high
   assign periph.spi_sdi = pad_in_i[PAD_SPIM_SDIO0 +: 4] & is_periph[PAD_SPIM_SDIO0 +: 4];
   assign periph.uart_rx = is_periph[PAD_UART_RX] ? pad_in_i[PAD_UART_RX] : 1'b1;

   assign i2c0_sda = is_periph[PAD_I2C0_SDA] ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c0_scl = is_periph[PAD_I2C0_SCL] ? pad_in_i[PAD_I2C0_SCL] : 1'b1;

   // I2C1, the SPI pads win over the UART pads
   assign i2c1_sda = is_alt[PAD_SPIM_SDIO2] ? pad_in_i[PAD_SPIM_SDIO2] :
                     is_alt[PAD_UART_RX]    ? pad_in_i[PAD_UART_RX]    : 1'b1;
   assign i2c1_scl = is_alt[PAD_SPIM_SDIO3] ? pad_in_i[PAD_SPIM_SDIO3] :
                     is_alt[PAD_UART_TX]    ? pad_in_i[PAD_UART_TX]    : 1'b1;

   assign periph.i2c_sda_in = {i2c1_sda, i2c0_sda};
   assign periph.i2c_scl_in = {i2c1_scl, i2c0_scl};

   ////////////////////
   // GPIO inputs

   assign periph.gpio_in = pad_in_i & is_gpio;

endmodule

//--- rtl/pad_control.sv
// Pad multiplexer top level
// Config register bank, output mux and input routing
// between the SoC peripherals and eleven pads

`timescale 1ns/1ps

module pad_control (
   input  logic                        clk_i,
   input  logic                        reset_i,

   // Config write port
   input  logic                        cfg_req_i,
   input  pad_ctrl_pkg::pad_idx_t      cfg_pad_i,
   input  pad_ctrl_pkg::pad_sel_e      cfg_sel_i,
   input  pad_ctrl_pkg::pad_cfg_t      cfg_pad_cfg_i,
   output logic                        cfg_ack_o,

   // SPI master
   input  logic                        spi_clk_i,
   input  logic [1:0]                  spi_csn_i,
   input  logic [3:0]                  spi_sdo_i,
   input  logic [3:0]                  spi_oen_i,
   output logic [3:0]                  spi_sdi_o,

   // UART
   input  logic                        uart_tx_i,
   output logic                        uart_rx_o,

   // I2C, bus 0 and bus 1
   input  logic [1:0]                  i2c_sda_out_i,
   input  logic [1:0]                  i2c_sda_oe_i,
   output logic [1:0]                  i2c_sda_in_o,
   input  logic [1:0]                  i2c_scl_out_i,
   input  logic [1:0]                  i2c_scl_oe_i,
   output logic [1:0]                  i2c_scl_in_o,

   // GPIO
   input  pad_ctrl_pkg::pad_vec_t      gpio_out_i,
   input  pad_ctrl_pkg::pad_vec_t      gpio_dir_i,
   input  pad_ctrl_pkg::pad_cfg_arr_t  gpio_cfg_i,
   output pad_ctrl_pkg::pad_vec_t      gpio_in_o,

   // Pad frame
   output pad_ctrl_pkg::pad_vec_t      pad_out_o,
   output pad_ctrl_pkg::pad_vec_t      pad_oe_o,
   input  pad_ctrl_pkg::pad_vec_t      pad_in_i,
   output pad_ctrl_pkg::pad_cfg_arr_t  pad_cfg_o
);
   import pad_ctrl_pkg::*;

   pad_sel_arr_t pad_sel;
   pad_cfg_arr_t pad_cfg;

   pad_periph_if periph_bus ();

   ////////////////////
   // Peripheral bundle

   assign periph_bus.spi_clk     = spi_clk_i;
   assign periph_bus.spi_csn     = spi_csn_i;
   assign periph_bus.spi_sdo     = spi_sdo_i;
   assign periph_bus.spi_oen     = spi_oen_i;
   assign periph_bus.uart_tx     = uart_tx_i;
   assign periph_bus.i2c_sda_out = i2c_sda_out_i;
   assign periph_bus.i2c_sda_oe  = i2c_sda_oe_i;
   assign periph_bus.i2c_scl_out = i2c_scl_out_i;
   assign periph_bus.i2c_scl_oe  = i2c_scl_oe_i;
   assign periph_bus.gpio_out    = gpio_out_i;
   assign periph_bus.gpio_dir    = gpio_dir_i;
   assign periph_bus.gpio_cfg    = gpio_cfg_i;

   assign spi_sdi_o    = periph_bus.spi_sdi;
   assign uart_rx_o    = periph_bus.uart_rx;
   assign i2c_sda_in_o = periph_bus.i2c_sda_in;
   assign i2c_scl_in_o = periph_bus.i2c_scl_in;
   assign gpio_in_o    = periph_bus.gpio_in;

   ////////////////////
   // Instances

   pad_cfg_regs pad_cfg_regs_inst (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cfg_req_i     (cfg_req_i),
      .cfg_pad_i     (cfg_pad_i),
      .cfg_sel_i     (cfg_sel_i),
      .cfg_pad_cfg_i (cfg_pad_cfg_i),
      .cfg_ack_o     (cfg_ack_o),
      .pad_sel_o     (pad_sel),
      .pad_cfg_o     (pad_cfg)
   );

   pad_out_mux pad_out_mux_inst (
      .periph    (periph_bus.out_side),
      .pad_sel_i (pad_sel),
      .pad_cfg_i (pad_cfg),
      .pad_out_o (pad_out_o),
      .pad_oe_o  (pad_oe_o),
      .pad_cfg_o (pad_cfg_o)
   );

   pad_in_route pad_in_route_inst (
      .periph    (periph_bus.in_side),
      .pad_sel_i (pad_sel),
      .pad_in_i  (pad_in_i)
   );

endmodule

//--- verif/tb_pad_control.sv
// Testbench for the pad multiplexer
// Reads write, drive and check lines from the pattern file,
// runs the config handshake and compares all routed signals

`timescale 1ns/1ps

module tb_pad_control;
   import pad_ctrl_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int RESET_CYCLES    = 4;
   localparam int CYCLES_PER_LINE = 10;
   localparam int HS_TIMEOUT      = 8;

   logic         clk_i = 1'b0;
   logic         reset_i;
   logic         cfg_req_i;
   pad_idx_t     cfg_pad_i;
   pad_sel_e     cfg_sel_i;
   pad_cfg_t     cfg_pad_cfg_i;
   logic         cfg_ack_o;
   logic         spi_clk_i;
   logic [1:0]   spi_csn_i;
   logic [3:0]   spi_sdo_i;
   logic [3:0]   spi_oen_i;
   logic [3:0]   spi_sdi_o;
   logic         uart_tx_i;
   logic         uart_rx_o;
   logic [1:0]   i2c_sda_out_i;
   logic [1:0]   i2c_sda_oe_i;
   logic [1:0]   i2c_sda_in_o;
   logic [1:0]   i2c_scl_out_i;
   logic [1:0]   i2c_scl_oe_i;
   logic [1:0]   i2c_scl_in_o;
   pad_vec_t     gpio_out_i;
   pad_vec_t     gpio_dir_i;
   pad_cfg_arr_t gpio_cfg_i;
   pad_vec_t     gpio_in_o;
   pad_vec_t     pad_out_o;
   pad_vec_t     pad_oe_o;
   pad_vec_t     pad_in_i;
   pad_cfg_arr_t pad_cfg_o;

   string lines[$];
   logic  loaded = 1'b0;
   int    test_errs;
   int    total_errs = 0;
   int    pass_cnt = 0;
   int    fail_cnt = 0;

   pad_control pad_control_inst (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   ////////////////////
   // Helpers

   task automatic compare(input string test, input string field,
                          input logic [15:0] exp, input logic [15:0] act);
      if (exp !== act) begin
         $display("ERROR %s %s: expected %h, actual %h", test, field, exp, act);
         test_errs++;
      end
   endtask

   task automatic close_test(input string test);
      total_errs += test_errs;
      if (test_errs == 0) begin
         pass_cnt++;
         $display("PASS %s", test);
      end else begin
         fail_cnt++;
         $display("FAIL %s (%0d errors)", test, test_errs);
      end
   endtask

   // Four-phase write that starts and ends 1 ns after a rising edge
   task automatic write_pad(input logic [15:0] pad, input logic [15:0] sel,
                            input logic [15:0] cfg);
      string name;
      int    n;
      name = $sformatf("write_pad_%0h", pad);
      test_errs = 0;
      cfg_pad_i     = pad[3:0];
      cfg_sel_i     = pad_sel_e'(sel[1:0]);
      cfg_pad_cfg_i = cfg[5:0];
      cfg_req_i     = 1'b1;
      n = 0;
      while (!cfg_ack_o && n < HS_TIMEOUT) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (!cfg_ack_o) begin
         $display("%s: ack never rose after req was raised", name);
         test_errs++;
      end
      cfg_req_i = 1'b0;
      @(posedge clk_i);
      #1;
      n = 1;
      while (cfg_ack_o && n < HS_TIMEOUT) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (cfg_ack_o) begin
         $display("%s: ack stayed high after req was dropped", name);
         test_errs++;
      end
      close_test(name);
   endtask

   task automatic drive_inputs(input string line);
      string       tag;
      logic [15:0] v[13];
      int          cnt;
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                    v[9], v[10], v[11], v[12]);
      if (cnt != 14) begin
         $display("Malformed drive line in pattern file: %s", line);
         total_errs++;
      end
      spi_clk_i     = v[0][0];
      spi_csn_i     = v[1][1:0];
      spi_sdo_i     = v[2][3:0];
      spi_oen_i     = v[3][3:0];
      uart_tx_i     = v[4][0];
      i2c_sda_out_i = v[5][1:0];
      i2c_sda_oe_i  = v[6][1:0];
      i2c_scl_out_i = v[7][1:0];
      i2c_scl_oe_i  = v[8][1:0];
      gpio_out_i    = v[9][N_PADS-1:0];
      gpio_dir_i    = v[10][N_PADS-1:0];
      for (int p = 0; p < N_PADS; p++) begin
         gpio_cfg_i[p] = v[11][PAD_CFG_W-1:0];
      end
      pad_in_i      = v[12][N_PADS-1:0];
   endtask

   // Sampled just before the next rising edge
   task automatic check_outputs(input string line);
      string       tag;
      string       name;
      logic [15:0] e[7];
      logic [15:0] c[11];
      int          cnt;
      cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tag, name, e[0], e[1], e[2], e[3], e[4], e[5], e[6],
                    c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9], c[10]);
      test_errs = 0;
      if (cnt != 20) begin
         $display("Malformed check line in pattern file: %s", line);
         test_errs++;
      end
      #(CLK_PERIOD - 2);
      compare(name, "pad_out", e[0], 16'(pad_out_o));
      compare(name, "pad_oe", e[1], 16'(pad_oe_o));
      compare(name, "spi_sdi", e[2], 16'(spi_sdi_o));
      compare(name, "uart_rx", e[3], 16'(uart_rx_o));
      compare(name, "i2c_sda_in", e[4], 16'(i2c_sda_in_o));
      compare(name, "i2c_scl_in", e[5], 16'(i2c_scl_in_o));
      compare(name, "gpio_in", e[6], 16'(gpio_in_o));
      for (int p = 0; p < N_PADS; p++) begin
         compare(name, $sformatf("pad_cfg[%0d]", p), c[p], 16'(pad_cfg_o[p]));
      end
      if (cfg_ack_o !== 1'b0) begin
         $display("%s: cfg_ack_o is high with no write in progress", name);
         test_errs++;
      end
      close_test(name);
      @(posedge clk_i);
      #1;
   endtask

   ////////////////////
   // Watchdog

   initial begin
      wait (loaded);
      #((lines.size() * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired before all patterns were run");
      $display("Simulation failed");
      $finish;
   end

   ////////////////////
   // Main sequence

   initial begin
      int          fd;
      string       line;
      string       tag;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      int          cnt;

      reset_i       = 1'b1;
      cfg_req_i     = 1'b0;
      cfg_pad_i     = '0;
      cfg_sel_i     = FUNC_PERIPH;
      cfg_pad_cfg_i = '0;
      spi_clk_i     = 1'b0;
      spi_csn_i     = '0;
      spi_sdo_i     = '0;
      spi_oen_i     = '0;
      uart_tx_i     = 1'b0;
      i2c_sda_out_i = '0;
      i2c_sda_oe_i  = '0;
      i2c_scl_out_i = '0;
      i2c_scl_oe_i  = '0;
      gpio_out_i    = '0;
      gpio_dir_i    = '0;
      gpio_cfg_i    = '0;
      pad_in_i      = '0;

      fd = $fopen("verif/pad_patterns.txt", "r");
      if (fd == 0) begin
         $display("Could not open the pattern file verif/pad_patterns.txt");
         $display("Simulation failed");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
               if (line.len() > 1 && line.getc(0) != "#") begin
                  lines.push_back(line);
               end
            end
         end
         $fclose(fd);
         loaded = 1'b1;

         repeat (RESET_CYCLES) @(posedge clk_i);
         #1;
         reset_i = 1'b0;

         foreach (lines[i]) begin
            cnt = $sscanf(lines[i], "%s", tag);
            if (tag == "W") begin
               cnt = $sscanf(lines[i], "%s %h %h %h", tag, a, b, c);
               if (cnt != 4) begin
                  $display("Malformed write line in pattern file: %s", lines[i]);
                  total_errs++;
               end else begin
                  write_pad(a, b, c);
               end
            end else if (tag == "D") begin
               drive_inputs(lines[i]);
            end else if (tag == "C") begin
               check_outputs(lines[i]);
            end else begin
               $display("Unknown line kind in pattern file: %s", lines[i]);
               total_errs++;
            end
         end

         $display("Tests: %0d, passed: %0d, failed: %0d, errors: %0d",
                  pass_cnt + fail_cnt, pass_cnt, fail_cnt, total_errs);
         if (total_errs == 0) begin
            $display("Simulation passed");
         end else begin
            $display("Simulation failed");
         end
         $finish;
      end
   end

endmodule

//--- verif/pad_patterns.txt
# W pad sel cfg  (hex)
# D spi_clk spi_csn spi_sdo spi_oen uart_tx sda_out sda_oe scl_out scl_oe
#   gpio_out gpio_dir gpio_cfg(all pads) pad_in
# C name pad_out pad_oe spi_sdi uart_rx sda_in scl_in gpio_in pad_cfg[0] .. pad_cfg[10]
D 1 2 5 3 1 1 3 2 1 7ff 000 2a 5a5
C reset_periph 365 77c 5 1 2 3 000 00 00 00 00 00 00 00 00 00 00 00
# Out-of-range address is acknowledged only
W b 1 3f
C out_of_range 365 77c 5 1 2 3 000 00 00 00 00 00 00 00 00 00 00 00
# sdio0 and uart_rx to GPIO, csn0 config only
W 0 1 15
W 7 1 0c
W 4 0 21
D 1 2 5 3 1 1 3 2 1 7fe 081 2a 5a5
C gpio_select 3e4 7fd 4 1 2 3 081 2a 00 00 00 21 00 00 2a 00 00 00
# I2C1 on sdio2/sdio3, scl also on uart_tx
W 2 2 00
W 3 2 00
W 8 2 07
C alt_sdio 3e8 6f5 0 1 2 1 081 2a 00 00 00 21 00 00 2a 07 00 00
# sdio3 unused, uart_rx to alternate
W 3 3 00
W 7 2 11
D 1 2 5 3 1 1 3 2 1 7fe 081 2a 4a1
C alt_priority 360 6f5 0 1 0 1 001 2a 00 00 00 21 00 00 11 07 00 00
# sdio2 back to SPI, sda comes from uart_rx
W 2 0 00
C alt_uart_sda 364 6f5 0 1 2 1 001 2a 00 00 00 21 00 00 11 07 00 00
# I2C0 pads moved away, sdio1 unused
W 9 3 05
W a 1 09
W 1 3 00
C unused_select 564 0f5 0 1 3 1 401 2a 00 00 00 21 00 00 11 07 05 2a

//--- project.f
rtl/pad_ctrl_pkg.sv
rtl/pad_periph_if.sv
rtl/pad_cfg_regs.sv
rtl/pad_out_mux.sv
rtl/pad_in_route.sv
rtl/pad_control.sv
verif/tb_pad_control.sv

//--- Makefile
# Verilator build and run for the pad multiplexer

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f project.f --top-module tb_pad_control -o Vtb_pad_control

run: build
	./obj_dir/Vtb_pad_control | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	verilator --lint-only --timing -f project.f --top-module tb_pad_control
	verilator --lint-only rtl/pad_ctrl_pkg.sv rtl/pad_periph_if.sv rtl/pad_cfg_regs.sv \
		rtl/pad_out_mux.sv rtl/pad_in_route.sv rtl/pad_control.sv --top-module pad_control

clean:
	rm -rf obj_dir $(LOG)
